//--- source/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and address width
`define CORE_XLEN 32

// Register index width and count
`define CORE_REG_BITS 5
`define CORE_NUM_REGS 32

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// ADDI x0,x0,0
`define CORE_NOP 32'h0000_0013

`endif

//--- source/isa_pkg.sv
`include "core_defines.svh"

package isa_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [`CORE_REG_BITS-1:0] reg_idx_t;

    // Major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BNE  = 3'b001;

    // Selects SUB and SRA/SRAI
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm_10_1;
        logic       imm11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        opcode_t    opcode;
    } j_fmt_t;

    // One instruction word seen as each format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

//--- source/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        // Branch compares
        ALU_EQ   = 4'd10,
        ALU_NE   = 4'd11
    } alu_op_t;

    // Carried from decode to writeback
    typedef enum logic [2:0] {
        CLS_ALU    = 3'd0,
        CLS_LOAD   = 3'd1,
        CLS_STORE  = 3'd2,
        CLS_BRANCH = 3'd3,
        CLS_JUMP   = 3'd4
    } op_class_t;

    typedef enum logic [1:0] {
        FROM_REG = 2'd0,
        FROM_MEM = 2'd1,
        FROM_WB  = 2'd2
    } fwd_sel_t;

endpackage

//--- source/fetch_stage.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module fetch_stage import isa_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  redirect,
    input  word_t redirect_pc,
    input  logic  load_stall,
    input  word_t instr,
    output word_t pc,
    output word_t if_pc,
    output word_t if_instr
);

    word_t pc_next;

    // Redirect has priority over a load-use stall
    always_comb begin
        if (redirect)
            pc_next = redirect_pc;
        else if (load_stall)
            pc_next = pc;
        else
            pc_next = pc + 32'd4;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= `CORE_RESET_PC;
        else
            pc <= pc_next;
    end

    // Fetch-to-decode register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_pc    <= `CORE_RESET_PC;
            if_instr <= `CORE_NOP;
        end else if (redirect) begin
            // Squash the wrong-path word
            if_instr <= `CORE_NOP;
        end else if (!load_stall) begin
            if_pc    <= pc;
            if_instr <= instr;
        end
    end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     if_pc,
    input  word_t     if_instr,
    input  logic      redirect,
    input  logic      wb_we,
    input  reg_idx_t  wb_rd,
    input  word_t     wb_result,
    output logic      load_stall,
    output word_t     ex_pc,
    output word_t     ex_rs1_val,
    output word_t     ex_rs2_val,
    output word_t     ex_imm,
    output reg_idx_t  ex_rs1,
    output reg_idx_t  ex_rs2,
    output reg_idx_t  ex_rd,
    output logic      ex_rd_we,
    output alu_op_t   ex_alu_op,
    output op_class_t ex_class,
    output logic      ex_use_imm
);

    instr_u    iw;
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    word_t     imm;
    word_t     rs1_val;
    word_t     rs2_val;
    alu_op_t   alu_op;
    op_class_t op_class;
    logic      rd_we;
    logic      use_imm;
    word_t     regs [`CORE_NUM_REGS];

    assign iw = if_instr;

    function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // Unused source indices are forced to x0 so they never stall or forward
    always_comb begin
        rs1_idx  = iw.r_fmt.rs1;
        rs2_idx  = '0;
        imm      = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
        alu_op   = ALU_ADD;
        op_class = CLS_ALU;
        rd_we    = 1'b0;
        use_imm  = 1'b1;
        case (iw.r_fmt.opcode)
            OPC_OP: begin
                rs2_idx = iw.r_fmt.rs2;
                alu_op  = alu_decode(iw.r_fmt.funct3, iw.r_fmt.funct7 == F7_ALT);
                rd_we   = 1'b1;
                use_imm = 1'b0;
            end
            OPC_OP_IMM: begin
                // Only the shift-right immediate uses the alternate bit
                alu_op = alu_decode(iw.r_fmt.funct3,
                                    iw.r_fmt.funct3 == F3_SR && iw.r_fmt.funct7 == F7_ALT);
                rd_we  = 1'b1;
            end
            OPC_LUI: begin
                // x0 plus the upper immediate
                rs1_idx = '0;
                imm     = {iw.u_fmt.imm, 12'b0};
                rd_we   = 1'b1;
            end
            OPC_LOAD: begin
                op_class = CLS_LOAD;
                rd_we    = 1'b1;
            end
            OPC_STORE: begin
                rs2_idx  = iw.s_fmt.rs2;
                imm      = {{20{iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};
                op_class = CLS_STORE;
            end
            OPC_BRANCH: begin
                rs2_idx  = iw.b_fmt.rs2;
                imm      = {{19{iw.b_fmt.imm12}}, iw.b_fmt.imm12, iw.b_fmt.imm11,
                            iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
                alu_op   = (iw.b_fmt.funct3 == F3_BNE) ? ALU_NE : ALU_EQ;
                op_class = CLS_BRANCH;
                use_imm  = 1'b0;
            end
            OPC_JAL: begin
                rs1_idx  = '0;
                imm      = {{11{iw.j_fmt.imm20}}, iw.j_fmt.imm20, iw.j_fmt.imm_19_12,
                            iw.j_fmt.imm11, iw.j_fmt.imm_10_1, 1'b0};
                op_class = CLS_JUMP;
                rd_we    = 1'b1;
            end
            default: begin
                // Unknown opcode runs as a bubble
                rs1_idx = '0;
            end
        endcase
    end

    // Register file read with same-cycle writeback bypass
    function automatic word_t rf_read(input reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (wb_we && wb_rd == idx)
            return wb_result;
        return regs[idx];
    endfunction

    always_comb begin
        rs1_val = rf_read(rs1_idx);
        rs2_val = rf_read(rs2_idx);
    end

    always_ff @(posedge clk) begin
        if (wb_we)
            regs[wb_rd] <= wb_result;
    end

    // Load in execute feeding this instruction
    assign load_stall = ex_class == CLS_LOAD && ex_rd != '0 &&
                        (ex_rd == rs1_idx || ex_rd == rs2_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_class <= CLS_ALU;
            ex_rd_we <= 1'b0;
        end else if (load_stall || redirect) begin
            ex_class <= CLS_ALU;
            ex_rd_we <= 1'b0;
        end else begin
            ex_class <= op_class;
            ex_rd_we <= rd_we;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc      <= if_pc;
        ex_rs1_val <= rs1_val;
        ex_rs2_val <= rs2_val;
        ex_imm     <= imm;
        ex_rs1     <= rs1_idx;
        ex_rs2     <= rs2_idx;
        ex_rd      <= iw.r_fmt.rd;
        ex_alu_op  <= alu_op;
        ex_use_imm <= use_imm;
    end

endmodule

//--- source/execute_stage.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     ex_pc,
    input  word_t     ex_rs1_val,
    input  word_t     ex_rs2_val,
    input  word_t     ex_imm,
    input  reg_idx_t  ex_rs1,
    input  reg_idx_t  ex_rs2,
    input  reg_idx_t  ex_rd,
    input  logic      ex_rd_we,
    input  alu_op_t   ex_alu_op,
    input  op_class_t ex_class,
    input  logic      ex_use_imm,
    input  logic      wb_we,
    input  reg_idx_t  wb_rd,
    input  word_t     wb_result,
    output logic      redirect,
    output word_t     redirect_pc,
    output op_class_t mem_class,
    output reg_idx_t  mem_rd,
    output logic      mem_rd_we,
    output word_t     mem_result,
    output word_t     mem_store_data
);

    localparam int SHAMT_BITS = $clog2(`CORE_XLEN);

    fwd_sel_t              sel_a;
    fwd_sel_t              sel_b;
    word_t                 op_a;
    word_t                 op_b;
    word_t                 rs2_fwd;
    word_t                 alu_res;
    word_t                 result;
    logic [SHAMT_BITS-1:0] shamt;
    logic                  equal;

    // Newer stage wins; a load in memory has no data yet
    function automatic fwd_sel_t fwd_pick(input reg_idx_t rs);
        if (rs == '0)
            return FROM_REG;
        if (mem_rd_we && mem_class != CLS_LOAD && mem_rd == rs)
            return FROM_MEM;
        if (wb_we && wb_rd == rs)
            return FROM_WB;
        return FROM_REG;
    endfunction

    function automatic word_t fwd_value(input fwd_sel_t sel, input word_t reg_val);
        case (sel)
            FROM_MEM: return mem_result;
            FROM_WB:  return wb_result;
            default:  return reg_val;
        endcase
    endfunction

    always_comb begin
        sel_a   = fwd_pick(ex_rs1);
        sel_b   = fwd_pick(ex_rs2);
        op_a    = fwd_value(sel_a, ex_rs1_val);
        rs2_fwd = fwd_value(sel_b, ex_rs2_val);
        op_b    = ex_use_imm ? ex_imm : rs2_fwd;
    end

    assign shamt = op_b[SHAMT_BITS-1:0];

    always_comb begin
        case (ex_alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_res = word_t'(op_a < op_b);
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = word_t'($signed(op_a) >>> shamt);
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = '0;
        endcase
    end

    // JAL writes the link address
    assign result = (ex_class == CLS_JUMP) ? ex_pc + 32'd4 : alu_res;

    assign equal       = op_a == op_b;
    assign redirect    = ex_class == CLS_JUMP ||
                         (ex_class == CLS_BRANCH && (ex_alu_op == ALU_NE ? !equal : equal));
    assign redirect_pc = ex_pc + ex_imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_class <= CLS_ALU;
            mem_rd_we <= 1'b0;
        end else begin
            mem_class <= ex_class;
            mem_rd_we <= ex_rd_we;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd         <= ex_rd;
        mem_result     <= result;
        mem_store_data <= rs2_fwd;
    end

endmodule

//--- source/memory_writeback.sv
`timescale 1ns/100ps

module memory_writeback import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  op_class_t mem_class,
    input  reg_idx_t  mem_rd,
    input  logic      mem_rd_we,
    input  word_t     mem_result,
    input  word_t     mem_store_data,
    input  word_t     mem_rdata,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output logic      mem_we,
    output logic      mem_re,
    output logic      wb_we,
    output reg_idx_t  wb_rd,
    output word_t     wb_result
);

    logic  wb_load;
    word_t wb_alu;
    word_t wb_rdata;

    // Data port with one pulse per access
    assign mem_addr  = mem_result;
    assign mem_wdata = mem_store_data;
    assign mem_we    = mem_class == CLS_STORE;
    assign mem_re    = mem_class == CLS_LOAD;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we   <= 1'b0;
            wb_load <= 1'b0;
        end else begin
            // Writes to x0 are dropped here
            wb_we   <= mem_rd_we && mem_rd != '0;
            wb_load <= mem_class == CLS_LOAD;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd    <= mem_rd;
        wb_alu   <= mem_result;
        wb_rdata <= mem_rdata;
    end

    assign wb_result = wb_load ? wb_rdata : wb_alu;

endmodule

//--- source/riscv_core.sv
`timescale 1ns/100ps

module riscv_core import isa_pkg::*, pipe_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    output word_t pc,
    input  word_t instr,
    output word_t mem_addr,
    output word_t mem_wdata,
    output logic  mem_we,
    output logic  mem_re,
    input  word_t mem_rdata
);

    // Fetch to decode
    word_t     if_pc;
    word_t     if_instr;
    logic      load_stall;
    logic      redirect;
    word_t     redirect_pc;

    // Decode to execute
    word_t     ex_pc;
    word_t     ex_rs1_val;
    word_t     ex_rs2_val;
    word_t     ex_imm;
    reg_idx_t  ex_rs1;
    reg_idx_t  ex_rs2;
    reg_idx_t  ex_rd;
    logic      ex_rd_we;
    alu_op_t   ex_alu_op;
    op_class_t ex_class;
    logic      ex_use_imm;

    // Execute to memory
    op_class_t mem_class;
    reg_idx_t  mem_rd;
    logic      mem_rd_we;
    word_t     mem_result;
    word_t     mem_store_data;

    // Writeback to register file and forwarding
    logic      wb_we;
    reg_idx_t  wb_rd;
    word_t     wb_result;

    // Stage ports share their names with the nets above
    fetch_stage i_fetch (.*);

    decode_stage i_decode (.*);

    execute_stage i_execute (.*);

    memory_writeback i_mem_wb (.*);

endmodule

//--- testbench/tb_riscv_core.sv
`timescale 1ns/100ps

module tb_riscv_core import isa_pkg::*; ();

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    // Enough for any store already in flight to reach memory
    localparam int DRAIN_CYCLES = 8;

    logic  clk = 1'b0;
    logic  rst_n;
    word_t pc;
    word_t instr;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_we;
    logic  mem_re;
    word_t mem_rdata;

    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t preload_addr [$];

    int num_words;
    int exp_reads;
    int reads;
    int store_idx;
    int cycles;
    int limit;
    int addr_errors;
    int data_errors;
    int read_errors;
    int extra_errors;
    int missing_errors;
    int file_errors;

    riscv_core i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc        (pc),
        .instr     (instr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_rdata (mem_rdata)
    );

    always #4 clk = ~clk;

    // Both memories answer in the same cycle
    assign instr     = imem[pc[9:2]];
    assign mem_rdata = dmem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_we)
            dmem[mem_addr[9:2]] <= mem_wdata;
    end

    task automatic load_vectors();
        integer fd;
        integer ch;
        integer n;
        word_t  addr;
        word_t  data;
        int     bad;
        bad = 0;
        // Unused slots hold ADDI x0,x0,<address>
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = {i[9:0], 2'b00, 20'h00013};
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] = 32'h5a5a_0000 | {22'd0, i[7:0], 2'b00};
        fd = $fopen("testbench/core_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/core_vectors.txt");
            file_errors++;
            return;
        end
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == "#") begin
                while (ch != -1 && ch != "\n")
                    ch = $fgetc(fd);
            end else if (ch == "P") begin
                n = $fscanf(fd, "%h", data);
                if (n != 1)
                    bad++;
                if (num_words < IMEM_WORDS)
                    imem[num_words] = data;
                // Every load in the program reads memory once
                if (data[6:0] == OPC_LOAD)
                    exp_reads++;
                num_words++;
            end else if (ch == "D") begin
                n = $fscanf(fd, "%h %h", addr, data);
                if (n != 2)
                    bad++;
                dmem[addr[9:2]] = data;
                preload_addr.push_back(addr);
            end else if (ch == "S") begin
                n = $fscanf(fd, "%h %h", addr, data);
                if (n != 2)
                    bad++;
                exp_addr.push_back(addr);
                exp_data.push_back(data);
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
        if (bad > 0) begin
            $display("%0d records in testbench/core_vectors.txt could not be read", bad);
            file_errors++;
        end
        if (num_words > IMEM_WORDS) begin
            $display("Program of %0d words does not fit the instruction memory", num_words);
            file_errors++;
        end
    endtask

    task automatic check_addr(input word_t got, input word_t exp, input int idx);
        if (got !== exp) begin
            $display("error at %0d ns: store %0d went to address %h, expected %h",
                     $time, idx, got, exp);
            addr_errors++;
        end
    endtask

    task automatic check_data(input word_t got, input word_t exp, input int idx);
        if (got !== exp) begin
            $display("error at %0d ns: store %0d wrote %h, expected %h", $time, idx, got, exp);
            data_errors++;
        end
    endtask

    // Loads in the program only read preloaded words
    task automatic check_read(input word_t addr);
        bit hit;
        hit = 1'b0;
        foreach (preload_addr[i]) begin
            if (preload_addr[i] === addr)
                hit = 1'b1;
        end
        if (!hit) begin
            $display("error at %0d ns: load from address %h, which was not preloaded",
                     $time, addr);
            read_errors++;
        end
        reads++;
    endtask

    task automatic check_store();
        if (store_idx >= exp_addr.size()) begin
            $display("Unexpected store of %h to address %h beyond the expected list",
                     mem_wdata, mem_addr);
            extra_errors++;
        end else begin
            check_addr(mem_addr, exp_addr[store_idx], store_idx);
            check_data(mem_wdata, exp_data[store_idx], store_idx);
            store_idx++;
        end
    endtask

    task automatic sample_data_port();
        if (mem_we)
            check_store();
        if (mem_re)
            check_read(mem_addr);
    endtask

    initial begin
        rst_n = 1'b0;
        load_vectors();
        limit = 8 * num_words + 100;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // Stores are sampled at the edge that ends their memory cycle
        while (store_idx < exp_addr.size() && cycles < limit) begin
            @(posedge clk);
            cycles++;
            sample_data_port();
        end

        if (store_idx < exp_addr.size()) begin
            $display("Timed out after %0d cycles with %0d of %0d stores seen",
                     cycles, store_idx, exp_addr.size());
            missing_errors = exp_addr.size() - store_idx;
        end else begin
            // A late wrong-path store shows up here
            repeat (DRAIN_CYCLES) begin
                @(posedge clk);
                sample_data_port();
            end
        end

        if (reads != exp_reads) begin
            $display("error at %0d ns: %0d data reads seen, expected %0d",
                     $time, reads, exp_reads);
            read_errors++;
        end

        $display("Error counts: address %0d, data %0d, read %0d, extra %0d, missing %0d, file %0d",
                 addr_errors, data_errors, read_errors, extra_errors, missing_errors,
                 file_errors);
        if (addr_errors + data_errors + read_errors + extra_errors + missing_errors
            + file_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- testbench/core_vectors.txt
# P <word>: program word in address order from 0
# D <addr> <data>: data memory preload; S <addr> <data>: expected store, in order
P 10000093  # 00 addi x1,x0,256
P 00700113  # 04 addi x2,x0,7
P ffd00193  # 08 addi x3,x0,-3
P 40310233  # 0c sub  x4,x2,x3
P 0040a023  # 10 sw   x4,0(x1)
P 0021a2b3  # 14 slt  x5,x3,x2
P 00313333  # 18 sltu x6,x2,x3
P 002313b3  # 1c sll  x7,x6,x2
P 0053e3b3  # 20 or   x7,x7,x5
P 0070a223  # 24 sw   x7,4(x1)
P 80000437  # 28 lui  x8,0x80000
P 40445493  # 2c srai x9,x8,4
P 00445513  # 30 srli x10,x8,4
P 00a4c5b3  # 34 xor  x11,x9,x10
P 00b0a423  # 38 sw   x11,8(x1)
P 00500013  # 3c addi x0,x0,5
P 00200633  # 40 add  x12,x0,x2
P 00c0a623  # 44 sw   x12,12(x1)
P 0400a683  # 48 lw   x13,64(x1)
P 11168713  # 4c addi x14,x13,0x111 (load-use)
P 00e0a823  # 50 sw   x14,16(x1)
P 00c10663  # 54 beq  x2,x12,+12 taken
P 0000aa23  # 58 sw   x0,20(x1) squashed
P 0000ac23  # 5c sw   x0,24(x1) squashed
P 00311663  # 60 bne  x2,x3,+12 taken
P 0000ae23  # 64 sw   x0,28(x1) squashed
P 0200a023  # 68 sw   x0,32(x1) squashed
P 00310463  # 6c beq  x2,x3,+8 not taken
P 0020aa23  # 70 sw   x2,20(x1)
P 00c007ef  # 74 jal  x15,+12
P 0200a223  # 78 sw   x0,36(x1) squashed
P 0200a423  # 7c sw   x0,40(x1) squashed
P 00f0ac23  # 80 sw   x15,24(x1)
P 0000006f  # 84 jal  x0,0
D 00000140 12345678
S 00000100 0000000a  # 7 - (-3)
S 00000104 00000081  # (1 << 7) | 1
S 00000108 f0000000  # sra ^ srl of 0x80000000 by 4
S 0000010c 00000007  # x0 stayed zero
S 00000110 12345789  # loaded word + 0x111
S 00000114 00000007  # branch fell through
S 00000118 00000078  # jal link

//--- sim.f
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_writeback.sv
source/riscv_core.sv
testbench/tb_riscv_core.sv
